/* Bender.yml */
package:
  name: rv_core

sources:
  - source/rv_core_pkg.sv
  - source/fetch_unit.sv
  - source/reg_file.sv
  - source/decode_execute.sv
  - source/mem_stage.sv
  - source/rv_core.sv
  - target: simulation
    files:
      - sim/wb_mem_model.sv
      - sim/tb_rv_core.sv

/* rv_core.f */
source/rv_core_pkg.sv
source/fetch_unit.sv
source/reg_file.sv
source/decode_execute.sv
source/mem_stage.sv
source/rv_core.sv
sim/wb_mem_model.sv
sim/tb_rv_core.sv

/* sim/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

    import rv_core_pkg::*;

    localparam inst_t NOP = 32'h0000_0013;

    logic  mem2wb_inst_selfdefine_o;
    logic  reset;
    logic  ibus_cyc_o;
    logic  ibus_stb_o;
    addr_t ibus_adr_o;
    inst_t ibus_dat_i;
    logic  ibus_ack_i;
    logic  dbus_cyc_o;
    logic  dbus_stb_o;
    logic  dbus_we_o;
    addr_t dbus_adr_o;
    xlen_t dbus_dat_o;
    xlen_t dbus_dat_i;
    logic  dbus_ack_i;

    inst_t  prog [$];
    addr_t  exp_adr [$];
    xlen_t  exp_dat [$];
    addr_t  obs_adr [$];
    xlen_t  obs_dat [$];
    addr_t  exp_fetch;
    logic   reset_q = 1'b0;
    string  cur_test = "init";
    int     test_errs;
    int     total_errs = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    integer seed = 93483;

    rv_core uut (
        .mem2wb_inst_selfdefine_o (mem2wb_inst_selfdefine_o),
        .reset      (reset),
        .ibus_cyc_o (ibus_cyc_o),
        .ibus_stb_o (ibus_stb_o),
        .ibus_adr_o (ibus_adr_o),
        .ibus_dat_i (ibus_dat_i),
        .ibus_ack_i (ibus_ack_i),
        .dbus_cyc_o (dbus_cyc_o),
        .dbus_stb_o (dbus_stb_o),
        .dbus_we_o  (dbus_we_o),
        .dbus_adr_o (dbus_adr_o),
        .dbus_dat_o (dbus_dat_o),
        .dbus_dat_i (dbus_dat_i),
        .dbus_ack_i (dbus_ack_i)
    );

    wb_mem_model mem_model (
        .clk_i      (mem2wb_inst_selfdefine_o),
        .reset_i    (reset),
        .ibus_cyc_i (ibus_cyc_o),
        .ibus_stb_i (ibus_stb_o),
        .ibus_adr_i (ibus_adr_o),
        .ibus_dat_o (ibus_dat_i),
        .ibus_ack_o (ibus_ack_i),
        .dbus_cyc_i (dbus_cyc_o),
        .dbus_stb_i (dbus_stb_o),
        .dbus_we_i  (dbus_we_o),
        .dbus_adr_i (dbus_adr_o),
        .dbus_dat_i (dbus_dat_o),
        .dbus_dat_o (dbus_dat_i),
        .dbus_ack_o (dbus_ack_i)
    );

    initial begin
        mem2wb_inst_selfdefine_o = 1'b0;
        forever #4 mem2wb_inst_selfdefine_o = ~mem2wb_inst_selfdefine_o;
    end

    task automatic check_value(input string what, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("** Error: %s %s expected %h actual %h", cur_test, what, expected, actual);
            test_errs++;
            total_errs++;
        end
    endtask

    function automatic xlen_t fill_word(input int idx);
        return {32'(idx) * 32'h9E37_79B9, 32'h1234_0000 + 32'(idx)};
    endfunction

    function automatic inst_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t enc_sd(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_DOUBLE, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t enc_lui(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    // ISA model of the program, fills the expected store list
    function automatic void ref_run();
        xlen_t    r [32];
        xlen_t    m [256];
        inst_t    x;
        xlen_t    a;
        xlen_t    b;
        xlen_t    res;
        xlen_t    ea;
        logic     wr;
        reg_idx_t rd;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) m[i] = fill_word(i);
        exp_adr.delete();
        exp_dat.delete();
        foreach (prog[k]) begin
            x   = prog[k];
            rd  = x[11:7];
            a   = r[x[19:15]];
            b   = r[x[24:20]];
            wr  = 1'b1;
            res = '0;
            case (x[6:0])
                OPC_OP_IMM: begin
                    case (x[14:12])
                        F3_ADD:  res = a + {{52{x[31]}}, x[31:20]};
                        F3_XOR:  res = a ^ {{52{x[31]}}, x[31:20]};
                        F3_OR:   res = a | {{52{x[31]}}, x[31:20]};
                        F3_AND:  res = a & {{52{x[31]}}, x[31:20]};
                        default: wr = 1'b0;
                    endcase
                end
                OPC_OP: begin
                    if (x[31:25] == F7_SUB && x[14:12] == F3_ADD) begin
                        res = a - b;
                    end else if (x[31:25] != 7'b0) begin
                        wr = 1'b0;
                    end else begin
                        case (x[14:12])
                            F3_ADD:  res = a + b;
                            F3_XOR:  res = a ^ b;
                            F3_OR:   res = a | b;
                            F3_AND:  res = a & b;
                            default: wr = 1'b0;
                        endcase
                    end
                end
                OPC_LUI: res = {{32{x[31]}}, x[31:12], 12'b0};
                OPC_LOAD: begin
                    ea  = a + {{52{x[31]}}, x[31:20]};
                    wr  = (x[14:12] == F3_DOUBLE);
                    res = m[ea[10:3]];
                end
                OPC_STORE: begin
                    wr = 1'b0;
                    if (x[14:12] == F3_DOUBLE) begin
                        ea = a + {{52{x[31]}}, x[31:25], x[11:7]};
                        m[ea[10:3]] = b;
                        exp_adr.push_back(ea[31:0]);
                        exp_dat.push_back(b);
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 0) r[rd] = res;
        end
    endfunction

    // monitor for reset, fetch order and data-bus writes
    always @(posedge mem2wb_inst_selfdefine_o) begin
        reset_q <= reset;
        if (reset) begin
            exp_fetch = PC_START;
            if (reset_q && (ibus_cyc_o !== 1'b0 || ibus_stb_o !== 1'b0
                            || dbus_cyc_o !== 1'b0 || dbus_stb_o !== 1'b0)) begin
                $display("%s: bus cycle active during reset", cur_test);
                test_errs++;
                total_errs++;
            end
        end else begin
            if (ibus_cyc_o && ibus_stb_o && ibus_ack_i) begin
                check_value("fetch address", xlen_t'(exp_fetch), xlen_t'(ibus_adr_o));
                exp_fetch = exp_fetch + addr_t'(4);
            end
            if (dbus_cyc_o && dbus_stb_o && dbus_we_o && dbus_ack_i) begin
                obs_adr.push_back(dbus_adr_o);
                obs_dat.push_back(dbus_dat_o);
            end
        end
    end

    task automatic run_program(input string name);
        int    cycles;
        addr_t pad;
        cur_test  = name;
        test_errs = 0;
        @(posedge mem2wb_inst_selfdefine_o);
        reset <= 1'b1;
        for (int i = 0; i < 1024; i++) mem_model.imem[i] = NOP;
        foreach (prog[k]) mem_model.imem[k] = prog[k];
        for (int i = 0; i < 256; i++) mem_model.dmem[i] = fill_word(i);
        ref_run();
        obs_adr.delete();
        obs_dat.delete();
        repeat (16) @(posedge mem2wb_inst_selfdefine_o);
        reset <= 1'b0;
        cycles = 0;
        while (obs_adr.size() < exp_adr.size() && cycles < 5000) begin
            @(posedge mem2wb_inst_selfdefine_o);
            cycles++;
        end
        if (obs_adr.size() < exp_adr.size()) begin
            $display("%s: timed out waiting for stores", name);
            test_errs++;
            total_errs++;
        end
        // eight no-ops past the program drain the pipeline
        pad    = PC_START + addr_t'(4 * (prog.size() + 8));
        cycles = 0;
        while (exp_fetch < pad && cycles < 5000) begin
            @(posedge mem2wb_inst_selfdefine_o);
            cycles++;
        end
        if (exp_fetch < pad) begin
            $display("%s: timed out waiting for the fetch past the program", name);
            test_errs++;
            total_errs++;
        end
        check_value("store count", xlen_t'(exp_adr.size()), xlen_t'(obs_adr.size()));
        for (int k = 0; k < exp_adr.size() && k < obs_adr.size(); k++) begin
            check_value($sformatf("store %0d address", k), xlen_t'(exp_adr[k]),
                        xlen_t'(obs_adr[k]));
            check_value($sformatf("store %0d data", k), exp_dat[k], obs_dat[k]);
        end
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %-15s %s (%0d stores)", name, (test_errs == 0) ? "ok" : "FAIL",
                 obs_adr.size());
    endtask

    task automatic random_program();
        logic [2:0] f3s [4];
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [11:0] imm;
        f3s = '{F3_ADD, F3_XOR, F3_OR, F3_AND};
        prog.delete();
        for (int k = 0; k < 60; k++) begin
            rd  = $random(seed) & 7;
            rs1 = $random(seed) & 7;
            rs2 = $random(seed) & 7;
            imm = $random(seed);
            case ($random(seed) & 7)
                0: prog.push_back(enc_i(OPC_OP_IMM, F3_ADD, rd, rs1, imm));
                1: prog.push_back(enc_i(OPC_OP_IMM, f3s[$random(seed) & 3], rd, rs1, imm));
                2: prog.push_back(enc_r(imm[0] ? F7_SUB : 7'b0, F3_ADD, rd, rs1, rs2));
                3: prog.push_back(enc_r(7'b0, f3s[$random(seed) & 3], rd, rs1, rs2));
                4: prog.push_back(enc_lui(rd, {imm, imm[7:0]}));
                5: prog.push_back(enc_i(OPC_LOAD, F3_DOUBLE, rd, 5'd0, {imm[5:0], 3'b0}));
                default: prog.push_back(enc_sd(rs2, 5'd0, {imm[5:0], 3'b0}));
            endcase
        end
        for (int i = 1; i < 8; i++) begin
            prog.push_back(enc_sd(reg_idx_t'(i), 5'd0, 12'(12'h200 + 8 * i)));
        end
    endtask

    initial begin
        reset = 1'b1;

        prog.delete();
        run_program("reset");

        prog = '{enc_i(OPC_OP_IMM, F3_ADD, 1, 0, 12'h123),
                 enc_i(OPC_OP_IMM, F3_ADD, 2, 0, -12'sd5),
                 enc_i(OPC_OP_IMM, F3_AND, 3, 1, 12'h0F0),
                 enc_i(OPC_OP_IMM, F3_OR, 4, 2, 12'h300),
                 enc_i(OPC_OP_IMM, F3_XOR, 5, 1, 12'hFFF),
                 enc_r(7'b0, F3_ADD, 6, 1, 2),
                 enc_r(F7_SUB, F3_ADD, 7, 1, 2),
                 enc_r(7'b0, F3_AND, 8, 1, 2),
                 enc_r(7'b0, F3_OR, 9, 1, 4),
                 enc_r(7'b0, F3_XOR, 10, 1, 2),
                 enc_lui(11, 20'hABCDE),
                 enc_lui(12, 20'h80000),
                 enc_sd(1, 0, 12'h000), enc_sd(2, 0, 12'h008), enc_sd(3, 0, 12'h010),
                 enc_sd(4, 0, 12'h018), enc_sd(5, 0, 12'h020), enc_sd(6, 0, 12'h028),
                 enc_sd(7, 0, 12'h030), enc_sd(8, 0, 12'h038), enc_sd(9, 0, 12'h040),
                 enc_sd(10, 0, 12'h048), enc_sd(11, 0, 12'h050), enc_sd(12, 0, 12'h058)};
        run_program("alu");

        prog = '{enc_i(OPC_OP_IMM, F3_ADD, 1, 0, 12'd7),
                 enc_r(7'b0, F3_ADD, 2, 1, 1),
                 enc_r(F7_SUB, F3_ADD, 3, 2, 1),
                 enc_sd(3, 0, 12'h000),
                 enc_r(7'b0, F3_XOR, 4, 3, 2),
                 enc_sd(4, 0, 12'h008),
                 enc_i(OPC_OP_IMM, F3_ADD, 1, 1, 12'd1),
                 enc_i(OPC_OP_IMM, F3_ADD, 1, 1, 12'd1),
                 enc_sd(1, 0, 12'h010),
                 enc_i(OPC_OP_IMM, F3_ADD, 5, 0, 12'h040),
                 enc_sd(1, 5, 12'h008),
                 enc_r(7'b0, F3_ADD, 0, 1, 1),
                 enc_sd(0, 0, 12'h018)};
        run_program("forwarding");

        prog = '{enc_i(OPC_LOAD, F3_DOUBLE, 1, 0, 12'h100),
                 enc_r(7'b0, F3_ADD, 2, 1, 1),
                 enc_sd(2, 0, 12'h000),
                 enc_i(OPC_LOAD, F3_DOUBLE, 3, 0, 12'h108),
                 enc_sd(3, 0, 12'h008),
                 enc_i(OPC_LOAD, F3_DOUBLE, 4, 0, 12'h110),
                 enc_i(OPC_OP_IMM, F3_XOR, 6, 4, 12'hFFF),
                 enc_sd(6, 0, 12'h010),
                 enc_i(OPC_LOAD, F3_DOUBLE, 7, 0, 12'h008),
                 enc_i(OPC_OP_IMM, F3_ADD, 7, 7, 12'd1),
                 enc_sd(7, 0, 12'h018)};
        run_program("load_use");

        random_program();
        run_program("random_program");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (tests_failed == 0 && total_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim/wb_mem_model.sv */
`timescale 1ns/10ps

module wb_mem_model (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               ibus_cyc_i,
    input  logic               ibus_stb_i,
    input  rv_core_pkg::addr_t ibus_adr_i,
    output rv_core_pkg::inst_t ibus_dat_o,
    output logic               ibus_ack_o,
    input  logic               dbus_cyc_i,
    input  logic               dbus_stb_i,
    input  logic               dbus_we_i,
    input  rv_core_pkg::addr_t dbus_adr_i,
    input  rv_core_pkg::xlen_t dbus_dat_i,
    output rv_core_pkg::xlen_t dbus_dat_o,
    output logic               dbus_ack_o
);

    import rv_core_pkg::*;

    // instruction words from PC_START, doublewords from address zero
    inst_t  imem [0:1023];
    xlen_t  dmem [0:255];
    integer seed = 93483;
    int     iwait;
    int     dwait;

    initial begin
        ibus_ack_o = 1'b0;
        dbus_ack_o = 1'b0;
        ibus_dat_o = '0;
        dbus_dat_o = '0;
    end

    // 0 to 3 wait cycles
    function automatic int rand_delay();
        return $random(seed) & 3;
    endfunction

    always @(posedge clk_i) begin
        if (reset_i) begin
            ibus_ack_o <= 1'b0;
            dbus_ack_o <= 1'b0;
            iwait      <= rand_delay();
            dwait      <= rand_delay();
        end else begin
            ibus_ack_o <= 1'b0;
            dbus_ack_o <= 1'b0;
            if (ibus_cyc_i && ibus_stb_i && !ibus_ack_o) begin
                if (iwait == 0) begin
                    ibus_ack_o <= 1'b1;
                    ibus_dat_o <= imem[ibus_adr_i[11:2]];
                    iwait      <= rand_delay();
                end else begin
                    iwait <= iwait - 1;
                end
            end
            if (dbus_cyc_i && dbus_stb_i && !dbus_ack_o) begin
                if (dwait == 0) begin
                    dbus_ack_o <= 1'b1;
                    dbus_dat_o <= dmem[dbus_adr_i[10:3]];
                    if (dbus_we_i) begin
                        dmem[dbus_adr_i[10:3]] <= dbus_dat_i;
                    end
                    dwait <= rand_delay();
                end else begin
                    dwait <= dwait - 1;
                end
            end
        end
    end

endmodule

/* source/decode_execute.sv */
`timescale 1ns/10ps

module decode_execute (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  inst_valid_i,
    input  rv_core_pkg::inst_t    inst_i,
    output logic                  inst_take_o,
    input  logic                  mem_ready_i,
    input  logic                  fwd_valid_i,
    input  logic                  fwd_busy_i,
    input  rv_core_pkg::reg_idx_t fwd_rd_i,
    input  rv_core_pkg::xlen_t    fwd_data_i,
    input  logic                  wr_en_i,
    input  rv_core_pkg::reg_idx_t wr_idx_i,
    input  rv_core_pkg::xlen_t    wr_data_i,
    output logic                  mem_valid_o,
    output rv_core_pkg::mem_op_e  mem_op_o,
    output rv_core_pkg::reg_idx_t mem_rd_o,
    output logic                  mem_rd_en_o,
    output rv_core_pkg::addr_t    mem_addr_o,
    output rv_core_pkg::xlen_t    mem_wdata_o,
    output rv_core_pkg::xlen_t    alu_result_o
);

    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;

    alu_op_e    alu_op;
    mem_op_e    mem_op;
    xlen_t      imm;
    logic       use_imm;
    logic       use_rs1;
    logic       use_rs2;
    logic       rd_en;

    xlen_t      rf_rs1;
    xlen_t      rf_rs2;
    xlen_t      op_a;
    xlen_t      rs2_val;
    xlen_t      op_b;
    xlen_t      alu_res;
    logic       hazard;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];
    assign imm_i  = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_s  = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u  = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};

    // unsupported encodings fall through as no-ops
    always_comb begin
        alu_op  = ALU_ADD;
        mem_op  = MEM_NONE;
        imm     = imm_i;
        use_imm = 1'b1;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        rd_en   = 1'b0;
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = (opcode == OPC_OP);
                use_imm = (opcode == OPC_OP_IMM);
                rd_en   = 1'b1;
                case (funct3)
                    F3_ADD:  alu_op = (use_rs2 && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: rd_en  = 1'b0;
                endcase
                // only funct7 zero or sub is legal for register ops
                if (use_rs2 && funct7 != 7'b0 && !(funct7 == F7_SUB && funct3 == F3_ADD)) begin
                    rd_en = 1'b0;
                end
            end
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                imm    = imm_u;
                rd_en  = 1'b1;
            end
            OPC_LOAD: begin
                if (funct3 == F3_DOUBLE) begin
                    mem_op  = MEM_LOAD;
                    use_rs1 = 1'b1;
                    rd_en   = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_DOUBLE) begin
                    mem_op  = MEM_STORE;
                    imm     = imm_s;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
            end
            default: ;
        endcase
    end

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2),
        .wr_en_i    (wr_en_i),
        .wr_idx_i   (wr_idx_i),
        .wr_data_i  (wr_data_i)
    );

    // bypass from the entry in the memory stage
    assign op_a    = (fwd_valid_i && fwd_rd_i == rs1) ? fwd_data_i : rf_rs1;
    assign rs2_val = (fwd_valid_i && fwd_rd_i == rs2) ? fwd_data_i : rf_rs2;
    assign op_b    = use_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // load result not back yet
    assign hazard = fwd_busy_i && ((use_rs1 && rs1 == fwd_rd_i) || (use_rs2 && rs2 == fwd_rd_i));
    assign inst_take_o = inst_valid_i && mem_ready_i && !hazard;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_valid_o <= 1'b0;
        end else if (mem_ready_i) begin
            mem_valid_o <= inst_take_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_take_o) begin
            mem_op_o     <= mem_op;
            mem_rd_o     <= rd;
            mem_rd_en_o  <= rd_en && (rd != '0);
            mem_addr_o   <= alu_res[ADDR_W-1:0];
            mem_wdata_o  <= rs2_val;
            alu_result_o <= alu_res;
        end
    end

    // a held entry does not change under back-pressure
    a_entry_hold : assert property (
        @(posedge clk_i) disable iff (reset_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) && $stable(mem_op_o)
    );

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               ibus_ack_i,
    input  rv_core_pkg::inst_t ibus_dat_i,
    input  logic               inst_take_i,
    output logic               ibus_cyc_o,
    output logic               ibus_stb_o,
    output rv_core_pkg::addr_t ibus_adr_o,
    output logic               inst_valid_o,
    output rv_core_pkg::inst_t inst_o
);

    import rv_core_pkg::*;

    addr_t pc_q;
    logic  req_q;
    logic  buf_valid_q;
    inst_t buf_inst_q;
    logic  buf_free;
    logic  fetch_done;

    // next fetch only when the buffer is empty or drained this cycle
    assign buf_free   = !buf_valid_q || inst_take_i;
    assign fetch_done = req_q && ibus_ack_i;

    // pc and wishbone read cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q  <= PC_START;
            req_q <= 1'b0;
        end else if (fetch_done) begin
            pc_q  <= pc_q + addr_t'(4);
            req_q <= 1'b0;
        end else if (!req_q && buf_free) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            buf_valid_q <= 1'b0;
        end else if (fetch_done) begin
            buf_valid_q <= 1'b1;
        end else if (inst_take_i) begin
            buf_valid_q <= 1'b0;
        end
    end

    // instruction word captured on the ack edge
    always_ff @(posedge clk_i) begin
        if (fetch_done) begin
            buf_inst_q <= ibus_dat_i;
        end
    end

    assign ibus_cyc_o   = req_q;
    assign ibus_stb_o   = req_q;
    assign ibus_adr_o   = pc_q;
    assign inst_valid_o = buf_valid_q;
    assign inst_o       = buf_inst_q;

    // address held until the slave answers
    a_ibus_adr_stable : assert property (
        @(posedge clk_i) disable iff (reset_i)
        ibus_stb_o && !ibus_ack_i |=> $stable(ibus_adr_o)
    );

endmodule

/* source/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  mem_valid_i,
    input  rv_core_pkg::mem_op_e  mem_op_i,
    input  rv_core_pkg::reg_idx_t mem_rd_i,
    input  logic                  mem_rd_en_i,
    input  rv_core_pkg::addr_t    mem_addr_i,
    input  rv_core_pkg::xlen_t    mem_wdata_i,
    input  rv_core_pkg::xlen_t    alu_result_i,
    output logic                  mem_ready_o,
    output logic                  fwd_valid_o,
    output logic                  fwd_busy_o,
    output rv_core_pkg::reg_idx_t fwd_rd_o,
    output rv_core_pkg::xlen_t    fwd_data_o,
    output logic                  wr_en_o,
    output rv_core_pkg::reg_idx_t wr_idx_o,
    output rv_core_pkg::xlen_t    wr_data_o,
    output logic                  dbus_cyc_o,
    output logic                  dbus_stb_o,
    output logic                  dbus_we_o,
    output rv_core_pkg::addr_t    dbus_adr_o,
    output rv_core_pkg::xlen_t    dbus_dat_o,
    input  logic                  dbus_ack_i,
    input  rv_core_pkg::xlen_t    dbus_dat_i
);

    import rv_core_pkg::*;

    logic  req_q;
    logic  we_q;
    addr_t adr_q;
    xlen_t dat_q;
    logic  is_mem;
    logic  is_load;
    logic  bus_done;
    logic  retire;

    assign is_mem   = mem_valid_i && (mem_op_i != MEM_NONE);
    assign is_load  = mem_valid_i && (mem_op_i == MEM_LOAD);
    assign bus_done = req_q && dbus_ack_i;

    // alu entries leave after one cycle, memory entries on their ack
    assign retire      = mem_valid_i && (!is_mem || bus_done);
    assign mem_ready_o = !mem_valid_i || retire;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (bus_done) begin
            req_q <= 1'b0;
        end else if (is_mem && !req_q) begin
            req_q <= 1'b1;
            we_q  <= (mem_op_i == MEM_STORE);
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_mem && !req_q) begin
            adr_q <= mem_addr_i;
            dat_q <= mem_wdata_i;
        end
    end

    assign dbus_cyc_o = req_q;
    assign dbus_stb_o = req_q;
    assign dbus_we_o  = we_q;
    assign dbus_adr_o = adr_q;
    assign dbus_dat_o = dat_q;

    // load data is final in its ack cycle
    assign fwd_valid_o = mem_valid_i && mem_rd_en_i && (!is_load || bus_done);
    assign fwd_busy_o  = is_load && mem_rd_en_i && !bus_done;
    assign fwd_rd_o    = mem_rd_i;
    assign fwd_data_o  = is_load ? dbus_dat_i : alu_result_i;

    assign wr_en_o   = retire && mem_rd_en_i;
    assign wr_idx_o  = mem_rd_i;
    assign wr_data_o = fwd_data_o;

    // a bus cycle only runs for the entry execute still holds
    a_dbus_stb_cyc : assert property (
        @(posedge clk_i) disable iff (reset_i)
        dbus_stb_o |-> dbus_cyc_o && mem_valid_i
    );

endmodule

/* source/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  rv_core_pkg::reg_idx_t rs1_i,
    input  rv_core_pkg::reg_idx_t rs2_i,
    output rv_core_pkg::xlen_t    rs1_data_o,
    output rv_core_pkg::xlen_t    rs2_data_o,
    input  logic                  wr_en_i,
    input  rv_core_pkg::reg_idx_t wr_idx_i,
    input  rv_core_pkg::xlen_t    wr_data_i
);

    import rv_core_pkg::*;

    // x1..x31, x0 has no storage
    xlen_t regs_q [1:31];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* source/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
    input  logic               mem2wb_inst_selfdefine_o,
    input  logic               reset,
    output logic               ibus_cyc_o,
    output logic               ibus_stb_o,
    output rv_core_pkg::addr_t ibus_adr_o,
    input  rv_core_pkg::inst_t ibus_dat_i,
    input  logic               ibus_ack_i,
    output logic               dbus_cyc_o,
    output logic               dbus_stb_o,
    output logic               dbus_we_o,
    output rv_core_pkg::addr_t dbus_adr_o,
    output rv_core_pkg::xlen_t dbus_dat_o,
    input  rv_core_pkg::xlen_t dbus_dat_i,
    input  logic               dbus_ack_i
);

    import rv_core_pkg::*;

    // fetch to decode
    logic     inst_valid;
    inst_t    inst;
    logic     inst_take;

    // execute register into the memory stage
    logic     mem_valid;
    mem_op_e  mem_op;
    reg_idx_t mem_rd;
    logic     mem_rd_en;
    addr_t    mem_addr;
    xlen_t    mem_wdata;
    xlen_t    alu_result;
    logic     mem_ready;

    // bypass and write-back
    logic     fwd_valid;
    logic     fwd_busy;
    reg_idx_t fwd_rd;
    xlen_t    fwd_data;
    logic     wr_en;
    reg_idx_t wr_idx;
    xlen_t    wr_data;

    fetch_unit u_fetch_unit (
        .clk_i        (mem2wb_inst_selfdefine_o),
        .reset_i      (reset),
        .ibus_ack_i   (ibus_ack_i),
        .ibus_dat_i   (ibus_dat_i),
        .inst_take_i  (inst_take),
        .ibus_cyc_o   (ibus_cyc_o),
        .ibus_stb_o   (ibus_stb_o),
        .ibus_adr_o   (ibus_adr_o),
        .inst_valid_o (inst_valid),
        .inst_o       (inst)
    );

    decode_execute u_decode_execute (
        .clk_i        (mem2wb_inst_selfdefine_o),
        .reset_i      (reset),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .inst_take_o  (inst_take),
        .mem_ready_i  (mem_ready),
        .fwd_valid_i  (fwd_valid),
        .fwd_busy_i   (fwd_busy),
        .fwd_rd_i     (fwd_rd),
        .fwd_data_i   (fwd_data),
        .wr_en_i      (wr_en),
        .wr_idx_i     (wr_idx),
        .wr_data_i    (wr_data),
        .mem_valid_o  (mem_valid),
        .mem_op_o     (mem_op),
        .mem_rd_o     (mem_rd),
        .mem_rd_en_o  (mem_rd_en),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .alu_result_o (alu_result)
    );

    mem_stage u_mem_stage (
        .clk_i        (mem2wb_inst_selfdefine_o),
        .reset_i      (reset),
        .mem_valid_i  (mem_valid),
        .mem_op_i     (mem_op),
        .mem_rd_i     (mem_rd),
        .mem_rd_en_i  (mem_rd_en),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .alu_result_i (alu_result),
        .mem_ready_o  (mem_ready),
        .fwd_valid_o  (fwd_valid),
        .fwd_busy_o   (fwd_busy),
        .fwd_rd_o     (fwd_rd),
        .fwd_data_o   (fwd_data),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_data_o    (wr_data),
        .dbus_cyc_o   (dbus_cyc_o),
        .dbus_stb_o   (dbus_stb_o),
        .dbus_we_o    (dbus_we_o),
        .dbus_adr_o   (dbus_adr_o),
        .dbus_dat_o   (dbus_dat_o),
        .dbus_ack_i   (dbus_ack_i),
        .dbus_dat_i   (dbus_dat_i)
    );

endmodule

/* source/rv_core_pkg.sv */
package rv_core_pkg;

    // datapath and bus widths
    localparam int XLEN   = 64;
    localparam int ILEN   = 32;
    localparam int ADDR_W = 32;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [ILEN-1:0]   inst_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [4:0]        reg_idx_t;

    // first fetch after reset
    localparam addr_t PC_START = 32'h8000_0000;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 codes
    localparam logic [2:0] F3_ADD    = 3'b000;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    // ld / sd width field
    localparam logic [2:0] F3_DOUBLE = 3'b011;

    // funct7 that turns add into sub
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // alu operations, pass-b carries the lui immediate
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    // data bus operation of an entry
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

endpackage
